/* source/cn_pkg.sv */
package cn_pkg;

    // one 32-bit unsigned word for currents, weights, extra drives and the neuron drive
    typedef logic [31:0] syn_current_t;

    typedef logic [3:0]  cfg_addr_t;    // config bank address
    typedef logic [31:0] cfg_data_t;    // config write word
    typedef logic [2:0]  scaler_t;      // button scaler, 1 to 5

    // config register map, anything above PARAM_EXTRA2 is ignored
    typedef enum cfg_addr_t {
        PARAM_WEIGHT_IA = 4'd0,         // Ia afferent synaptic weight
        PARAM_WEIGHT_II = 4'd1,         // II afferent synaptic weight
        PARAM_EXTRA1    = 4'd2,         // cortical extra drive 1
        PARAM_EXTRA2    = 4'd3          // cortical extra drive 2, gets the button scaler
    } param_sel_e;

    // scaler wraps from max back to min
    localparam scaler_t SCALER_MIN = 3'd1;
    localparam scaler_t SCALER_MAX = 3'd5;

    localparam syn_current_t PARAM_RESET_VALUE = 32'd0;  // every config reg after reset

endpackage : cn_pkg

/* source/cn_param_if.sv */
`timescale 1ns/1ps

interface cn_param_if;
    import cn_pkg::*;

    syn_current_t weight_ia;    // Ia synapse weight
    syn_current_t weight_ii;    // II synapse weight
    syn_current_t extra1;       // added straight into the drive
    syn_current_t extra2;       // scaled by the button first

    // register bank owns all four words
    modport bank (
        output weight_ia, weight_ii, extra1, extra2
    );

    // synapse side, top picks the right field per instance
    modport syn (
        input weight_ia, weight_ii
    );

    // drive combiner only needs the extra drives
    modport sum (
        input extra1, extra2
    );

endinterface : cn_param_if

/* source/cn_param_bank.sv */
`timescale 1ns/1ps

module cn_param_bank (
    input  logic              ep50trig,
    input  logic              reset_global,
    input  logic              i_cfg_valid,     // write strobe that is always accepted
    input  cn_pkg::cfg_addr_t i_cfg_addr,
    input  cn_pkg::cfg_data_t i_cfg_data,
    cn_param_if.bank          o_param
);
    import cn_pkg::*;

    logic addr_hit;     // address falls inside the register map

    assign addr_hit = i_cfg_addr inside {PARAM_WEIGHT_IA, PARAM_WEIGHT_II,
                                         PARAM_EXTRA1, PARAM_EXTRA2};

    // one write per strobe cycle with the new value visible next cycle
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_param.weight_ia <= PARAM_RESET_VALUE;
            o_param.weight_ii <= PARAM_RESET_VALUE;
            o_param.extra1    <= PARAM_RESET_VALUE;
            o_param.extra2    <= PARAM_RESET_VALUE;
        end else if (i_cfg_valid) begin
            case (param_sel_e'(i_cfg_addr))
                PARAM_WEIGHT_IA: o_param.weight_ia <= i_cfg_data;
                PARAM_WEIGHT_II: o_param.weight_ii <= i_cfg_data;
                PARAM_EXTRA1:    o_param.extra1    <= i_cfg_data;
                PARAM_EXTRA2:    o_param.extra2    <= i_cfg_data;
                default: ;      // unmapped address drops the write
            endcase
        end
    end

    // no write or a write outside the map leaves the whole bank untouched
    a_bank_hold : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (!i_cfg_valid || !addr_hit) |=>
            $stable({o_param.weight_ia, o_param.weight_ii,
                     o_param.extra1, o_param.extra2})
    ) else $error("config bank changed without a mapped write");

endmodule : cn_param_bank

/* source/cn_synapse.sv */
`timescale 1ns/1ps

module cn_synapse #(
    parameter int unsigned DECAY_SHIFT = 3     // leak = current >> DECAY_SHIFT per tick
) (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 i_sim_tick,   // one pulse per simulated ms
    input  logic                 i_spike,      // afferent spike line
    input  cn_pkg::syn_current_t i_weight,
    output cn_pkg::syn_current_t o_current
);
    import cn_pkg::*;

    logic         catch_q;      // spike seen since the last tick
    syn_current_t leak;         // amount lost this tick
    syn_current_t kick;         // weight added this tick or zero

    assign leak = o_current >> DECAY_SHIFT;
    // a spike in the tick cycle itself still counts
    assign kick = (catch_q || i_spike) ? i_weight : '0;

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            catch_q   <= 1'b0;
            o_current <= '0;
        end else if (i_sim_tick) begin
            o_current <= o_current - leak + kick;   // wraps mod 2^32
            catch_q   <= 1'b0;                      // consumed by this update
        end else if (i_spike) begin
            catch_q   <= 1'b1;
        end
    end

    // current moves only on the edge closing a tick cycle
    a_update_on_tick : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        $changed(o_current) |-> $past(i_sim_tick)
    ) else $error("synapse current changed outside a tick");

endmodule : cn_synapse

/* source/cn_gain_button.sv */
`timescale 1ns/1ps

module cn_gain_button (
    input  logic            ep50trig,
    input  logic            reset_global,
    input  logic            i_button,      // raw button level async to ep50trig
    output cn_pkg::scaler_t o_scaler
);
    import cn_pkg::*;

    logic button_meta;      // first sync stage
    logic button_sync;      // second sync stage
    logic level_change;     // stages disagree for one cycle per edge

    // two-flop synchronizer
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            button_meta <= 1'b0;
            button_sync <= 1'b0;
        end else begin
            button_meta <= i_button;
            button_sync <= button_meta;
        end
    end

    assign level_change = button_meta ^ button_sync;   // either edge steps the scaler

    // 1,2,3,4,5,1,... one step per level change
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            o_scaler <= SCALER_MIN;
        end else if (level_change) begin
            if (o_scaler == SCALER_MAX) begin
                o_scaler <= SCALER_MIN;
            end else begin
                o_scaler <= o_scaler + 3'd1;
            end
        end
    end

    // scaler stays inside its wrap bounds
    a_scaler_range : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_scaler >= SCALER_MIN) && (o_scaler <= SCALER_MAX)
    ) else $error("scaler out of range: %0d", o_scaler);

endmodule : cn_gain_button

/* source/cn_drive_sum.sv */
`timescale 1ns/1ps

module cn_drive_sum #(
    parameter int unsigned SUM_SHIFT = 9     // gain on the summed afferent current
) (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  logic                 i_sim_tick,
    input  cn_pkg::syn_current_t i_current_ia,
    input  cn_pkg::syn_current_t i_current_ii,
    cn_param_if.sum              i_param,
    input  cn_pkg::scaler_t      i_scaler,
    output cn_pkg::syn_current_t o_drive,
    output logic                 o_drive_valid,
    input  logic                 i_drive_ready
);
    import cn_pkg::*;

    logic         tick_d;           // tick delayed one cycle, currents are fresh now
    syn_current_t afferent_sum;     // Ia + II
    syn_current_t extra2_scaled;    // extra2 * button scaler
    syn_current_t drive_next;       // full drive, mod 2^32
    logic         load;             // take drive_next into the output reg

    assign afferent_sum  = i_current_ia + i_current_ii;
    assign extra2_scaled = i_param.extra2 * i_scaler;
    // shift applies to the afferent sum only, extras go in unshifted
    assign drive_next    = (afferent_sum << SUM_SHIFT) + i_param.extra1 + extra2_scaled;

    // drop the new sample when the held one is still waiting
    assign load = tick_d && (!o_drive_valid || i_drive_ready);

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            tick_d        <= 1'b0;
            o_drive       <= '0;
            o_drive_valid <= 1'b0;
        end else begin
            tick_d <= i_sim_tick;
            if (load) begin
                o_drive       <= drive_next;
                o_drive_valid <= 1'b1;
            end else if (i_drive_ready) begin
                o_drive_valid <= 1'b0;              // sample taken, nothing new
            end
        end
    end

    // held sample does not move under back-pressure
    a_drive_stable : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_drive_valid && !i_drive_ready) |=> $stable(o_drive)
    ) else $error("o_drive changed while waiting for ready");

    // valid only drops after a transfer
    a_valid_hold : assert property (
        @(posedge ep50trig) disable iff (reset_global)
        (o_drive_valid && !i_drive_ready) |=> o_drive_valid
    ) else $error("o_drive_valid fell without a transfer");

endmodule : cn_drive_sum

/* source/cn_node_top.sv */
`timescale 1ns/1ps

module cn_node_top #(
    parameter int unsigned DECAY_SHIFT = 3,    // synapse leak rate
    parameter int unsigned SUM_SHIFT   = 9     // afferent current gain
) (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    // config write port
    input  logic                 i_cfg_valid,
    input  cn_pkg::cfg_addr_t    i_cfg_addr,
    input  cn_pkg::cfg_data_t    i_cfg_data,
    input  logic                 i_sim_tick,
    input  logic                 i_spike_ia,
    input  logic                 i_spike_ii,
    input  logic                 i_button,
    // drive sample out
    output cn_pkg::syn_current_t o_drive,
    output logic                 o_drive_valid,
    input  logic                 i_drive_ready,
    output cn_pkg::scaler_t      o_scaler
);
    import cn_pkg::*;

    syn_current_t current_ia;   // Ia synaptic current
    syn_current_t current_ii;   // II synaptic current

    cn_param_if param0 ();

    cn_param_bank bank0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cfg_valid  (i_cfg_valid),
        .i_cfg_addr   (i_cfg_addr),
        .i_cfg_data   (i_cfg_data),
        .o_param      (param0.bank)
    );

    cn_synapse #(.DECAY_SHIFT(DECAY_SHIFT)) syn_ia (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_sim_tick (i_sim_tick),
        .i_spike  (i_spike_ia), .i_weight (param0.weight_ia), .o_current (current_ia)
    );

    cn_synapse #(.DECAY_SHIFT(DECAY_SHIFT)) syn_ii (
        .ep50trig (ep50trig), .reset_global (reset_global), .i_sim_tick (i_sim_tick),
        .i_spike  (i_spike_ii), .i_weight (param0.weight_ii), .o_current (current_ii)
    );

    cn_gain_button button0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_button     (i_button),
        .o_scaler     (o_scaler)
    );

    cn_drive_sum #(.SUM_SHIFT(SUM_SHIFT)) sum0 (
        .ep50trig      (ep50trig),
        .reset_global  (reset_global),
        .i_sim_tick    (i_sim_tick),
        .i_current_ia  (current_ia),
        .i_current_ii  (current_ii),
        .i_param       (param0.sum),
        .i_scaler      (o_scaler),      // scaler also leaves the node
        .o_drive       (o_drive),
        .o_drive_valid (o_drive_valid),
        .i_drive_ready (i_drive_ready)
    );

endmodule : cn_node_top

/* dv/cn_node_checker.sv */
`timescale 1ns/1ps

module cn_node_checker (
    input  logic                 ep50trig,
    input  logic                 reset_global,
    input  cn_pkg::syn_current_t i_drive,         // dut o_drive
    input  logic                 i_drive_valid,
    input  logic                 i_drive_ready,
    input  logic                 i_valid_exp,     // model output reg full
    input  cn_pkg::scaler_t      i_scaler,        // dut o_scaler
    input  cn_pkg::scaler_t      i_scaler_exp,    // model scaler
    output int                   o_errors,
    output int                   o_checked        // accepted samples compared
);
    import cn_pkg::*;

    syn_current_t expect_q[$];  // model drives in load order
    syn_current_t held_drive;   // o_drive seen at the last negedge
    syn_current_t exp_drive;
    logic         held_wait;    // last negedge had valid and no ready

    initial begin
        o_errors  = 0;
        o_checked = 0;
        held_wait = 1'b0;
    end

    // model side calls this when the dut would load its output reg
    task automatic push_expected(input syn_current_t value);
        expect_q.push_back(value);
    endtask

    function automatic int pending();
        return expect_q.size();
    endfunction

    // sampled at negedge when everything has settled
    always @(negedge ep50trig) begin
        if (reset_global) begin
            if (i_drive_valid !== 1'b0) begin
                $display("o_drive_valid is high while the node is in reset");
                o_errors++;
            end
            if (i_drive !== '0) begin
                $display("FAILED o_drive: expected %h got %h", 32'h0, i_drive);
                o_errors++;
            end
            if (i_scaler !== SCALER_MIN) begin
                $display("FAILED o_scaler: expected %h got %h", SCALER_MIN, i_scaler);
                o_errors++;
            end
            held_wait = 1'b0;
        end else begin
            if (i_drive_valid !== i_valid_exp) begin
                $display("FAILED o_drive_valid: expected %h got %h",
                         i_valid_exp, i_drive_valid);
                o_errors++;
            end
            if (held_wait && i_drive !== held_drive) begin   // sink stalled last cycle
                $display("FAILED o_drive: expected %h got %h", held_drive, i_drive);
                o_errors++;
            end
            if (i_scaler !== i_scaler_exp) begin
                $display("FAILED o_scaler: expected %h got %h", i_scaler_exp, i_scaler);
                o_errors++;
            end
            // valid and ready both high here means a transfer on the next edge
            if (i_drive_valid && i_drive_ready) begin
                if (expect_q.size() == 0) begin
                    $display("drive sample transferred while none was expected");
                    o_errors++;
                end else begin
                    exp_drive = expect_q.pop_front();
                    o_checked++;
                    if (i_drive !== exp_drive) begin
                        $display("FAILED o_drive: expected %h got %h", exp_drive, i_drive);
                        o_errors++;
                    end
                end
            end
            held_wait  = i_drive_valid && !i_drive_ready;
            held_drive = i_drive;
        end
    end

endmodule : cn_node_checker

/* dv/tb_cn_node.sv */
`timescale 1ns/1ps

module tb_cn_node;
    import cn_pkg::*;

    localparam int DECAY_SHIFT   = 3;
    localparam int SUM_SHIFT     = 9;
    localparam int CLK_PERIOD    = 8;     // ns
    localparam int N_TICKS       = 60;
    localparam int TICK_GAP      = 16;    // cycles between sim ticks
    localparam int MARGIN_CYCLES = 400;   // reset plus drain headroom

    logic         ep50trig;
    logic         reset_global;
    logic         i_cfg_valid;
    cfg_addr_t    i_cfg_addr;
    cfg_data_t    i_cfg_data;
    logic         i_sim_tick;
    logic         i_spike_ia;
    logic         i_spike_ii;
    logic         i_button;
    logic         i_drive_ready;
    syn_current_t o_drive;
    logic         o_drive_valid;
    scaler_t      o_scaler;

    integer seed = 32'h7406;
    int     t;
    int     slot;
    int     tb_errors = 0;
    int     chk_errors;
    int     chk_checked;

    // model state
    syn_current_t w_ia_m, w_ii_m, ex1_m, ex2_m;
    syn_current_t cur_ia_m, cur_ii_m, drive_m;
    logic         catch_ia_m, catch_ii_m, sync1_m, sync2_m, tick_d_m, full_m, load_m;
    scaler_t      scaler_m;

    always #(CLK_PERIOD / 2) ep50trig = ~ep50trig;

    cn_node_top #(.DECAY_SHIFT(DECAY_SHIFT), .SUM_SHIFT(SUM_SHIFT)) dut0 (
        .ep50trig (ep50trig), .reset_global (reset_global),
        .i_cfg_valid (i_cfg_valid), .i_cfg_addr (i_cfg_addr), .i_cfg_data (i_cfg_data),
        .i_sim_tick (i_sim_tick), .i_spike_ia (i_spike_ia), .i_spike_ii (i_spike_ii),
        .i_button (i_button), .o_drive (o_drive), .o_drive_valid (o_drive_valid),
        .i_drive_ready (i_drive_ready), .o_scaler (o_scaler)
    );

    cn_node_checker chk0 (
        .ep50trig (ep50trig), .reset_global (reset_global),
        .i_drive (o_drive), .i_drive_valid (o_drive_valid), .i_drive_ready (i_drive_ready),
        .i_valid_exp (full_m),
        .i_scaler (o_scaler), .i_scaler_exp (scaler_m),
        .o_errors (chk_errors), .o_checked (chk_checked)
    );

    // reference model sees last cycle's inputs at the edge
    always @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            {w_ia_m, w_ii_m, ex1_m, ex2_m} = '0;
            {cur_ia_m, cur_ii_m} = '0;
            {catch_ia_m, catch_ii_m, sync1_m, sync2_m, tick_d_m, full_m} = '0;
            scaler_m = SCALER_MIN;
        end else begin
            // drive from currents updated on the tick edge and summed before the shift
            drive_m = ((cur_ia_m + cur_ii_m) << SUM_SHIFT) + ex1_m + ex2_m * scaler_m;
            load_m  = tick_d_m && (!full_m || i_drive_ready);   // else dropped
            if (load_m)
                chk0.push_expected(drive_m);
            full_m   = load_m ? 1'b1 : (i_drive_ready ? 1'b0 : full_m);
            tick_d_m = i_sim_tick;
            if (i_sim_tick) begin                               // leaky update with old weights
                cur_ia_m = cur_ia_m - (cur_ia_m >> DECAY_SHIFT)
                           + ((catch_ia_m || i_spike_ia) ? w_ia_m : 32'd0);
                cur_ii_m = cur_ii_m - (cur_ii_m >> DECAY_SHIFT)
                           + ((catch_ii_m || i_spike_ii) ? w_ii_m : 32'd0);
                catch_ia_m = 1'b0;
                catch_ii_m = 1'b0;
            end else begin
                catch_ia_m = catch_ia_m || i_spike_ia;
                catch_ii_m = catch_ii_m || i_spike_ii;
            end
            if (i_cfg_valid) begin
                case (i_cfg_addr)
                    PARAM_WEIGHT_IA: w_ia_m = i_cfg_data;
                    PARAM_WEIGHT_II: w_ii_m = i_cfg_data;
                    PARAM_EXTRA1:    ex1_m  = i_cfg_data;
                    PARAM_EXTRA2:    ex2_m  = i_cfg_data;
                    default: ;                                  // unmapped
                endcase
            end
            if (sync1_m != sync2_m)
                scaler_m = (scaler_m == SCALER_MAX) ? SCALER_MIN : scaler_m + 3'd1;
            sync2_m = sync1_m;
            sync1_m = i_button;
        end
    end

    // watchdog sized from tick count and spacing
    initial begin
        #((N_TICKS * TICK_GAP + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired before the drive stream drained");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        ep50trig = 1'b0;
        reset_global = 1'b1;
        i_cfg_valid = 1'b0;
        i_cfg_addr = '0;
        i_cfg_data = '0;
        i_sim_tick = 1'b0;
        i_spike_ia = 1'b0;
        i_spike_ii = 1'b0;
        i_button = 1'b0;
        i_drive_ready = 1'b1;
        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;

        // tick phases are quiet, spikes, button, config and back-pressure
        for (t = 0; t < N_TICKS; t++) begin
            for (slot = 0; slot < TICK_GAP; slot++) begin
                @(posedge ep50trig);
                i_sim_tick  <= (slot == 0);
                i_spike_ia  <= (t >= 8) && (($random(seed) & 7) == 0);
                i_spike_ii  <= (t >= 8) && (($random(seed) & 7) == 0);
                i_cfg_valid <= 1'b0;
                if (t == 0 && slot >= 2 && slot <= 5) begin    // initial parameter load
                    i_cfg_valid <= 1'b1;
                    i_cfg_addr  <= cfg_addr_t'(slot - 2);
                    i_cfg_data  <= (slot < 4) ? ($random(seed) & 32'hffff)
                                              : ($random(seed) & 32'hfffff);
                end
                if (t >= 20 && t < 32 && slot == 6)
                    i_button <= ~i_button;                      // held a full gap
                if (t >= 32 && t < 44 && (slot == 3 || slot == 9)) begin
                    i_cfg_valid <= 1'b1;
                    i_cfg_addr  <= cfg_addr_t'($random(seed)); // hits unused addresses too
                    i_cfg_data  <= $random(seed);
                end
                if (t >= 44)
                    i_drive_ready <= (($random(seed) & 15) == 0);
            end
        end

        @(posedge ep50trig);
        i_sim_tick    <= 1'b0;
        i_spike_ia    <= 1'b0;
        i_spike_ii    <= 1'b0;
        i_cfg_valid   <= 1'b0;
        i_drive_ready <= 1'b1;
        @(negedge ep50trig);
        while (chk0.pending() != 0 || o_drive_valid)
            @(negedge ep50trig);
        repeat (4) @(negedge ep50trig);

        if (chk_checked == 0) begin
            $display("no drive sample was ever transferred");
            tb_errors++;
        end
        $display("checker errors: %0d, testbench errors: %0d, samples checked: %0d",
                 chk_errors, tb_errors, chk_checked);
        if (chk_errors == 0 && tb_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule : tb_cn_node

/* list.f */
source/cn_pkg.sv
source/cn_param_if.sv
source/cn_param_bank.sv
source/cn_synapse.sv
source/cn_gain_button.sv
source/cn_drive_sum.sv
source/cn_node_top.sv
dv/cn_node_checker.sv
dv/tb_cn_node.sv

/* Bender.yml */
package:
  name: cn_node

sources:
  - files:
      - source/cn_pkg.sv
      - source/cn_param_if.sv
      - source/cn_param_bank.sv
      - source/cn_synapse.sv
      - source/cn_gain_button.sv
      - source/cn_drive_sum.sv
      - source/cn_node_top.sv
  - target: test
    files:
      - dv/cn_node_checker.sv
      - dv/tb_cn_node.sv
